// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= ring_router_tb
FILELIST  ?= tb.f
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== sim/ring_router_checker.sv ====
// Output monitor of the ring stop testbench.
// Holds the expected flit queues that the drivers fill and compares
// every transfer on the local and ring outputs against their heads.

`timescale 1ns/1ps
`default_nettype none

module ring_router_checker (
  input logic        clk,
  input logic        rst,
  input logic        ring_out_valid,
  input logic [15:0] ring_out_data,
  input logic        ring_out_last,
  input logic        ring_out_ready,
  input logic        local_out_valid,
  input logic [15:0] local_out_data,
  input logic        local_out_last,
  input logic        local_out_ready
);

  logic [16:0] q_local_out[$];  // {last, data} for the local output.
  logic [16:0] q_ring_fwd[$];   // forwarded ring flits.
  logic [16:0] q_local_inj[$];  // injected local flits.

  int   err_count  = 0;
  int   flit_count = 0;
  logic in_worm    = 1'b0;
  logic worm_tag   = 1'b0;

  task automatic push_local_out(input logic [16:0] f);
    q_local_out.push_back(f);
  endtask

  task automatic push_ring_fwd(input logic [16:0] f);
    q_ring_fwd.push_back(f);
  endtask

  task automatic push_local_inj(input logic [16:0] f);
    q_local_inj.push_back(f);
  endtask

  function automatic int pending();
    return q_local_out.size() + q_ring_fwd.size() + q_local_inj.size();
  endfunction

  task automatic compare_flit(input string sig, input logic [16:0] exp,
                              input logic [15:0] data, input logic last);
    if (exp[15:0] !== data) begin
      $display("Mismatch at %0t: %s_data expected %h got %h", $time, sig, exp[15:0], data);
      err_count++;
    end
    if (exp[16] !== last) begin
      $display("Mismatch at %0t: %s_last expected %b got %b", $time, sig, exp[16], last);
      err_count++;
    end
    flit_count++;
  endtask

  // sample mid cycle, a valid and ready pair here moves on the next edge.
  always @(negedge clk) begin
    logic tag;
    if (!rst) begin
      if (local_out_valid && local_out_ready) begin
        if (q_local_out.size() == 0) begin
          $display("unexpected flit %h on local output at %0t", local_out_data, $time);
          err_count++;
        end else begin
          compare_flit("local_out", q_local_out.pop_front(), local_out_data, local_out_last);
        end
      end
      if (ring_out_valid && ring_out_ready) begin
        tag = in_worm ? worm_tag : ring_out_data[15];  // header picks the queue.
        if (tag && q_ring_fwd.size() != 0) begin
          compare_flit("ring_out", q_ring_fwd.pop_front(), ring_out_data, ring_out_last);
        end else if (!tag && q_local_inj.size() != 0) begin
          compare_flit("ring_out", q_local_inj.pop_front(), ring_out_data, ring_out_last);
        end else begin
          $display("unexpected flit %h on ring output at %0t", ring_out_data, $time);
          err_count++;
        end
        in_worm  = !ring_out_last;
        worm_tag = tag;
      end
    end
  end

endmodule

`default_nettype wire

// ==== sim/ring_router_props.sv ====
// Handshake and wormhole assertions for the ring stop.
// Bound to ring_router from the bind at the bottom of this file.
// Checks both outputs for stable flits under stall and single-source worms.

`timescale 1ns/1ps
`default_nettype none

module ring_router_props (
  input logic        clk,
  input logic        rst,
  input logic        ring_out_valid,
  input logic [15:0] ring_out_data,
  input logic        ring_out_last,
  input logic        ring_out_ready,
  input logic        local_out_valid,
  input logic [15:0] local_out_data,
  input logic        local_out_last,
  input logic        local_out_ready
);

  logic in_worm;   // ring output is between header and tail.
  logic worm_tag;  // source tag of the current ring output worm.

  int assert_fails = 0;  // failed assertion count, read by the testbench.

  always_ff @(posedge clk) begin
    if (rst) begin
      in_worm  <= 1'b0;
      worm_tag <= 1'b0;
    end else if (ring_out_valid && ring_out_ready) begin
      if (!in_worm) begin
        worm_tag <= ring_out_data[15];  // header fixes the owner.
      end
      in_worm <= !ring_out_last;
    end
  end

  // a stalled flit holds until it moves.
  ring_out_hold: assert property (@(posedge clk) disable iff (rst)
    ring_out_valid && !ring_out_ready |=>
      ring_out_valid && $stable(ring_out_data) && $stable(ring_out_last))
    else begin
      $error("ring output changed while stalled");
      assert_fails++;
    end

  local_out_hold: assert property (@(posedge clk) disable iff (rst)
    local_out_valid && !local_out_ready |=>
      local_out_valid && $stable(local_out_data) && $stable(local_out_last))
    else begin
      $error("local output changed while stalled");
      assert_fails++;
    end

  // no flit of another source inside a worm.
  worm_single_source: assert property (@(posedge clk) disable iff (rst)
    in_worm && ring_out_valid |-> ring_out_data[15] == worm_tag)
    else begin
      $error("ring output worm mixes sources");
      assert_fails++;
    end

endmodule

bind ring_router ring_router_props u_props (
  .clk             (clk),
  .rst             (rst),
  .ring_out_valid  (ring_out_valid),
  .ring_out_data   (ring_out_data),
  .ring_out_last   (ring_out_last),
  .ring_out_ready  (ring_out_ready),
  .local_out_valid (local_out_valid),
  .local_out_data  (local_out_data),
  .local_out_last  (local_out_last),
  .local_out_ready (local_out_ready)
);

`default_nettype wire

// ==== sim/ring_router_tb.sv ====
// Testbench top of the ring stop: clock, reset, packet drivers and
// the reference routing function. Runs local delivery, forwarding,
// injection, mixed traffic and output back-pressure in turn.

`timescale 1ns/1ps
`default_nettype none

module ring_router_tb;

  import dii_pkg::*;

  localparam logic [addr_width-1:0] router_id = 10'h005;
  localparam int timeout_cycles = 2000;  // per wait loop.
  localparam int num_packets    = 6;

  logic clk, rst;
  logic ring_in_valid, ring_in_last, ring_in_ready;
  logic ring_out_valid, ring_out_last, ring_out_ready;
  logic local_in_valid, local_in_last, local_in_ready;
  logic local_out_valid, local_out_last, local_out_ready;
  logic [flit_width-1:0] ring_in_data, ring_out_data, local_in_data, local_out_data;

  integer seed       = 32'h4cde_3b18;
  integer ready_seed = 32'h4cde_3b18 ^ 32'h1;  // own stream for the stall pattern.
  logic   bp_on      = 1'b0;
  int     fail_count = 0;  // wait timeouts.
  int     tests_run  = 0;

  ring_router #(.router_id(router_id), .buffer_depth(4)) DUT (.*);

  ring_router_checker chk (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // true when the header addresses this stop.
  function automatic logic expected_route(input logic [flit_width-1:0] header);
    return header[addr_width-1:0] == router_id;
  endfunction

  // mismatches, failed assertions and timeouts so far.
  function automatic int errors_so_far();
    return chk.err_count + fail_count + DUT.u_props.assert_fails;
  endfunction

  // output sinks, randomly stalled while back-pressure is on.
  initial begin
    ring_out_ready  = 1'b1;
    local_out_ready = 1'b1;
    forever begin
      @(posedge clk);
      #2;
      ring_out_ready  = bp_on ? 1'($random(ready_seed)) : 1'b1;
      local_out_ready = bp_on ? 1'($random(ready_seed)) : 1'b1;
    end
  end

  task automatic send_ring_flit(input logic [flit_width-1:0] d, input logic l);
    logic rdy;
    int   n;
    ring_in_valid = 1'b1;
    ring_in_data  = d;
    ring_in_last  = l;
    for (n = 0; n < timeout_cycles; n++) begin
      @(negedge clk);
      rdy = ring_in_ready;
      @(posedge clk);
      if (rdy) break;
    end
    if (n == timeout_cycles) begin
      $display("timeout: ring input never accepted flit %h", d);
      fail_count++;
    end
    #2;
  endtask

  task automatic send_local_flit(input logic [flit_width-1:0] d, input logic l);
    logic rdy;
    int   n;
    local_in_valid = 1'b1;
    local_in_data  = d;
    local_in_last  = l;
    for (n = 0; n < timeout_cycles; n++) begin
      @(negedge clk);
      rdy = local_in_ready;
      @(posedge clk);
      if (rdy) break;
    end
    if (n == timeout_cycles) begin
      $display("timeout: local input never accepted flit %h", d);
      fail_count++;
    end
    #2;
  endtask

  // header plus 0 to 4 body flits, bit 15 tags the ring as origin.
  task automatic send_ring_packet(input logic [addr_width-1:0] addr);
    logic [flit_width-1:0] f;
    logic                  to_local;
    int                    nbody;
    nbody    = ($random(seed) & 32'h7fff_ffff) % 5;
    f        = {1'b1, 5'($random(seed)), addr};
    to_local = expected_route(f);
    for (int i = 0; i <= nbody; i++) begin
      if (i > 0) f = {1'b1, 15'($random(seed))};
      if (to_local) chk.push_local_out({i == nbody, f});
      else chk.push_ring_fwd({i == nbody, f});
      send_ring_flit(f, i == nbody);
    end
    ring_in_valid = 1'b0;
  endtask

  task automatic send_local_packet();
    logic [flit_width-1:0] f;
    int                    nbody;
    nbody = ($random(seed) & 32'h7fff_ffff) % 5;
    for (int i = 0; i <= nbody; i++) begin
      f = {1'b0, 15'($random(seed))};  // tag 0 marks injection.
      chk.push_local_inj({i == nbody, f});
      send_local_flit(f, i == nbody);
    end
    local_in_valid = 1'b0;
  endtask

  function automatic logic [addr_width-1:0] other_addr();
    logic [addr_width-1:0] a;
    a = addr_width'($random(seed));
    if (a == router_id) a = a ^ 10'h200;
    return a;
  endfunction

  task automatic wait_drain();
    int n;
    for (n = 0; n < timeout_cycles; n++) begin
      @(posedge clk);
      if (chk.pending() == 0) break;
    end
    if (n == timeout_cycles) begin
      $display("timeout: %0d expected flits never left the router", chk.pending());
      fail_count++;
    end
    repeat (3) @(posedge clk);
    #2;
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (errors_so_far() == errs_before)
      $display("test %0d %s: ok", tests_run, name);
    else
      $display("test %0d %s: failed", tests_run, name);
  endtask

  initial begin
    int e0;
    rst            = 1'b1;
    ring_in_valid  = 1'b0;
    ring_in_data   = '0;
    ring_in_last   = 1'b0;
    local_in_valid = 1'b0;
    local_in_data  = '0;
    local_in_last  = 1'b0;
    repeat (5) @(posedge clk);
    #2;
    rst = 1'b0;
    @(posedge clk);
    #2;

    e0 = errors_so_far();
    for (int p = 0; p < num_packets; p++) send_ring_packet(router_id);
    wait_drain();
    finish_test("local delivery", e0);

    e0 = errors_so_far();
    for (int p = 0; p < num_packets; p++) send_ring_packet(other_addr());
    wait_drain();
    finish_test("forwarding", e0);

    e0 = errors_so_far();
    for (int p = 0; p < num_packets; p++) send_local_packet();
    wait_drain();
    finish_test("injection", e0);

    for (int t = 0; t < 2; t++) begin
      e0    = errors_so_far();
      bp_on = (t == 1);
      fork
        for (int p = 0; p < 2 * num_packets; p++)
          send_ring_packet(($random(seed) & 1) ? router_id : other_addr());
        for (int p = 0; p < 2 * num_packets; p++) send_local_packet();
      join
      wait_drain();
      bp_on = 1'b0;
      finish_test(t == 0 ? "wormhole integrity" : "back-pressure", e0);
    end

    $display("tests %0d, flits checked %0d, mismatches %0d, assertion failures %0d, %s %0d",
             tests_run, chk.flit_count, chk.err_count, DUT.u_props.assert_fails,
             "other failures", fail_count);
    if (errors_so_far() == 0 && chk.pending() == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
verilog/dii_pkg.sv
verilog/dii_channel_if.sv
verilog/ring_router_demux.sv
verilog/flit_fifo.sv
verilog/ring_router_mux.sv
verilog/ring_router.sv
sim/ring_router_props.sv
sim/ring_router_checker.sv
sim/ring_router_tb.sv

// ==== verilog/dii_channel_if.sv ====
// One flit channel of the ring with a valid/ready handshake.
// A flit moves on a rising edge where valid and ready are both high.
// The source side drives valid, data and last; the sink side drives ready.

`timescale 1ns/1ps
`default_nettype none

interface dii_channel_if #(
  parameter int flit_width = dii_pkg::flit_width
);

  logic                  valid;  // flit on data is meaningful.
  logic [flit_width-1:0] data;   // flit payload, header carries the address.
  logic                  last;   // final flit of the worm.
  logic                  ready;  // sink can take the flit.

  // producer of flits.
  modport source (
    output valid,
    output data,
    output last,
    input  ready
  );

  // consumer of flits.
  modport sink (
    input  valid,
    input  data,
    input  last,
    output ready
  );

endinterface

`default_nettype wire

// ==== verilog/dii_pkg.sv ====
// Shared definitions for the debug interconnect ring stop.
// Holds the flit and address widths and the FSM state encodings.
// Modules pull these in with a wildcard import in their body.

`default_nettype none

package dii_pkg;

  // flit payload, the ring carries 16-bit debug flits.
  parameter int flit_width = 16;

  // destination address sits in the low bits of a header flit.
  parameter int addr_width = 10;

  // demux worm tracking.
  typedef enum logic [1:0] {
    DM_IDLE,   // waiting for a header.
    DM_LOCAL,  // worm bound for the local port.
    DM_FWD     // worm bound for the ring buffer.
  } demux_state_e;

  // ring output arbiter worm tracking.
  typedef enum logic [1:0] {
    MX_IDLE,   // no worm owns the output.
    MX_RING,   // forwarded ring worm owns the output.
    MX_LOCAL   // injected local worm owns the output.
  } mux_state_e;

endpackage

`default_nettype wire

// ==== verilog/flit_fifo.sv ====
// Small synchronous flit buffer on the forward path of a ring stop.
// Stores data and last per entry; a written flit shows at the output
// one cycle later. Depth must be a power of two of at least 2.
// A full buffer still takes a flit when the output drains one.

`timescale 1ns/1ps
`default_nettype none

module flit_fifo #(
  parameter int buffer_depth = 4
) (
  input  logic          clk,
  input  logic          rst,
  dii_channel_if.sink   wr,
  dii_channel_if.source rd
);

  import dii_pkg::*;

  localparam int ptr_width = $clog2(buffer_depth);
  localparam int cnt_width = ptr_width + 1;

  logic [flit_width:0] mem [buffer_depth];  // {last, data} per entry.

  logic [ptr_width-1:0] wr_ptr;  // next slot to write.
  logic [ptr_width-1:0] rd_ptr;  // oldest stored flit.
  logic [cnt_width-1:0] count;   // occupied slots.

  logic full;
  logic empty;
  logic wr_en;
  logic rd_en;

  assign full  = (count == cnt_width'(buffer_depth));
  assign empty = (count == '0);

  // full blocks the writer unless the reader frees a slot this cycle.
  assign wr.ready = ~full | rd.ready;
  assign rd.valid = ~empty;
  assign rd.data  = mem[rd_ptr][flit_width-1:0];
  assign rd.last  = mem[rd_ptr][flit_width];

  assign wr_en = wr.valid & wr.ready;
  assign rd_en = rd.valid & rd.ready;

  // storage, no reset needed.
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= {wr.last, wr.data};
    end
  end

  // pointers wrap on their own since the depth is a power of two.
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;  // write only.
        2'b01:   count <= count - 1'b1;  // read only.
        default: count <= count;         // both or neither.
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== verilog/ring_router.sv ====
// Single router stop of the debug interconnect ring.
// Ring packets for this stop leave on the local output, others are
// buffered and merged with local injection onto the ring output.
// Set router_id to the stop address and buffer_depth to the forward buffer size.

`timescale 1ns/1ps
`default_nettype none

module ring_router #(
  parameter logic [dii_pkg::addr_width-1:0] router_id    = 10'h005,
  parameter int                             buffer_depth = 4
) (
  input  logic                          clk,
  input  logic                          rst,
  // ring input.
  input  logic                          ring_in_valid,
  input  logic [dii_pkg::flit_width-1:0] ring_in_data,
  input  logic                          ring_in_last,
  output logic                          ring_in_ready,
  // ring output.
  output logic                          ring_out_valid,
  output logic [dii_pkg::flit_width-1:0] ring_out_data,
  output logic                          ring_out_last,
  input  logic                          ring_out_ready,
  // local injection.
  input  logic                          local_in_valid,
  input  logic [dii_pkg::flit_width-1:0] local_in_data,
  input  logic                          local_in_last,
  output logic                          local_in_ready,
  // local delivery.
  output logic                          local_out_valid,
  output logic [dii_pkg::flit_width-1:0] local_out_data,
  output logic                          local_out_last,
  input  logic                          local_out_ready
);

  import dii_pkg::*;

  dii_channel_if #(.flit_width(flit_width)) ring_in_ch   ();
  dii_channel_if #(.flit_width(flit_width)) local_out_ch ();
  dii_channel_if #(.flit_width(flit_width)) fwd_ch       ();
  dii_channel_if #(.flit_width(flit_width)) fwd_buf_ch   ();
  dii_channel_if #(.flit_width(flit_width)) local_in_ch  ();
  dii_channel_if #(.flit_width(flit_width)) ring_out_ch  ();

  // ports onto channels.
  assign ring_in_ch.valid     = ring_in_valid;
  assign ring_in_ch.data      = ring_in_data;
  assign ring_in_ch.last      = ring_in_last;
  assign ring_in_ready        = ring_in_ch.ready;

  assign local_out_valid      = local_out_ch.valid;
  assign local_out_data       = local_out_ch.data;
  assign local_out_last       = local_out_ch.last;
  assign local_out_ch.ready   = local_out_ready;

  assign local_in_ch.valid    = local_in_valid;
  assign local_in_ch.data     = local_in_data;
  assign local_in_ch.last     = local_in_last;
  assign local_in_ready       = local_in_ch.ready;

  assign ring_out_valid       = ring_out_ch.valid;
  assign ring_out_data        = ring_out_ch.data;
  assign ring_out_last        = ring_out_ch.last;
  assign ring_out_ch.ready    = ring_out_ready;

  ring_router_demux #(.router_id(router_id)) u_demux (
    .clk       (clk),
    .rst       (rst),
    .ring_in   (ring_in_ch),
    .local_out (local_out_ch),
    .fwd_out   (fwd_ch)
  );

  flit_fifo #(.buffer_depth(buffer_depth)) u_fifo (
    .clk (clk),
    .rst (rst),
    .wr  (fwd_ch),
    .rd  (fwd_buf_ch)
  );

  ring_router_mux u_mux (
    .clk      (clk),
    .rst      (rst),
    .in_ring  (fwd_buf_ch),
    .in_local (local_in_ch),
    .out_mux  (ring_out_ch)
  );

endmodule

`default_nettype wire

// ==== verilog/ring_router_demux.sv ====
// Ring input demultiplexer of a router stop.
// The header address picks the local port or the forward path,
// and the choice is held until the worm's last flit has moved.
// Flits and ready pass through without a register stage.

`timescale 1ns/1ps
`default_nettype none

module ring_router_demux #(
  parameter logic [dii_pkg::addr_width-1:0] router_id = '0
) (
  input  logic          clk,
  input  logic          rst,
  dii_channel_if.sink   ring_in,
  dii_channel_if.source local_out,
  dii_channel_if.source fwd_out
);

  import dii_pkg::*;

  demux_state_e state, nxt_state;

  logic hdr_match;  // header addresses this stop.
  logic sel_local;  // current flit goes to the local port.
  logic sel_fwd;    // current flit goes to the forward path.
  logic xfer;       // flit accepted from the ring this cycle.

  assign hdr_match = (ring_in.data[addr_width-1:0] == router_id);

  // worm state overrides the header compare once a worm has started.
  always_comb begin
    sel_local = 1'b0;
    sel_fwd   = 1'b0;
    case (state)
      DM_IDLE: begin
        sel_local = ring_in.valid & hdr_match;
        sel_fwd   = ring_in.valid & ~hdr_match;
      end
      DM_LOCAL: sel_local = 1'b1;
      DM_FWD:   sel_fwd   = 1'b1;
      default: begin
        sel_local = 1'b0;
        sel_fwd   = 1'b0;
      end
    endcase
  end

  // payload fans out to both paths, only valid is steered.
  assign local_out.valid = ring_in.valid & sel_local;
  assign local_out.data  = ring_in.data;
  assign local_out.last  = ring_in.last;

  assign fwd_out.valid = ring_in.valid & sel_fwd;
  assign fwd_out.data  = ring_in.data;
  assign fwd_out.last  = ring_in.last;

  // ready comes only from the selected path, so it stays low while idle and empty.
  assign ring_in.ready = (sel_local & local_out.ready) | (sel_fwd & fwd_out.ready);

  assign xfer = ring_in.valid & ring_in.ready;

  always_comb begin
    nxt_state = state;
    case (state)
      DM_IDLE: begin
        if (xfer && !ring_in.last) begin  // single-flit worms never leave idle.
          nxt_state = hdr_match ? DM_LOCAL : DM_FWD;
        end
      end
      DM_LOCAL, DM_FWD: begin
        if (xfer && ring_in.last) begin   // tail flit closes the worm.
          nxt_state = DM_IDLE;
        end
      end
      default: nxt_state = DM_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= DM_IDLE;
    end else begin
      state <= nxt_state;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/ring_router_mux.sv ====
// Ring output arbiter of a router stop.
// Merges buffered ring traffic and local injection one worm at a time,
// ring first when both wait at a packet boundary. Flits pass through
// without a register stage and only the selected source sees ready.

`timescale 1ns/1ps
`default_nettype none

module ring_router_mux (
  input  logic          clk,
  input  logic          rst,
  dii_channel_if.sink   in_ring,
  dii_channel_if.sink   in_local,
  dii_channel_if.source out_mux
);

  import dii_pkg::*;

  mux_state_e state, nxt_state;

  logic pick_ring;   // ring buffer drives the output.
  logic pick_local;  // local injection drives the output.

  always_comb begin
    pick_ring  = 1'b0;
    pick_local = 1'b0;
    case (state)
      MX_IDLE: begin
        pick_ring  = in_ring.valid;                    // ring wins a tie.
        pick_local = ~in_ring.valid & in_local.valid;
      end
      MX_RING:  pick_ring  = 1'b1;
      MX_LOCAL: pick_local = 1'b1;
      default: begin
        pick_ring  = 1'b0;
        pick_local = 1'b0;
      end
    endcase
  end

  // output path.
  always_comb begin
    out_mux.valid = 1'b0;
    out_mux.data  = '0;
    out_mux.last  = 1'b0;
    if (pick_ring) begin
      out_mux.valid = in_ring.valid;
      out_mux.data  = in_ring.data;
      out_mux.last  = in_ring.last;
    end else if (pick_local) begin
      out_mux.valid = in_local.valid;
      out_mux.data  = in_local.data;
      out_mux.last  = in_local.last;
    end
  end

  assign in_ring.ready  = pick_ring  & out_mux.ready;
  assign in_local.ready = pick_local & out_mux.ready;

  // a flit left waiting in idle also locks its source,
  // so the output holds steady while the sink stalls.
  always_comb begin
    nxt_state = state;
    case (state)
      MX_IDLE: begin
        if (pick_ring && !(out_mux.ready && in_ring.last)) begin
          nxt_state = MX_RING;
        end else if (pick_local && !(out_mux.ready && in_local.last)) begin
          nxt_state = MX_LOCAL;
        end
      end
      MX_RING, MX_LOCAL: begin
        if (out_mux.valid && out_mux.ready && out_mux.last) begin
          nxt_state = MX_IDLE;  // tail moved, worm done.
        end
      end
      default: nxt_state = MX_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= MX_IDLE;
    end else begin
      state <= nxt_state;
    end
  end

endmodule

`default_nettype wire
